// ==== tests/frames_input.txt ====
# mode length listed, then the listed payload bytes in hex, rest of payload is random filler
# mode 0 single frame then drain, 1 back-to-back writes, 2 burst with random write gaps
0 64 64
ff ff ff ff ff ff 02 00 5e 10 00 01 08 00 45 00 00 32 1c 46 40 00 40 11 b8 61 c0 a8 00 0a c0 a8
00 14 04 d2 16 2e 00 1e 7a 3c 48 65 6c 6c 6f 20 52 4d 49 49 20 62 72 69 64 67 65 20 74 65 73 74
0 65 65
00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 0f 1e 2d 3c 4b 5a 69 78 87 96 a5 b4 c3 d2 e1 f0
01 02 04 08 10 20 40 80 fe fd fb f7 ef df bf 7f 55 d5 55 d5 aa 00 aa 00 13 57 9b df 24 68 ac e0
5a
0 66 16 c3 3c a5 5a 0f f0 69 96 12 34 56 78 9a bc de f0
0 67 16 80 40 20 10 08 04 02 01 7e 81 3c c3 e7 18 db 24
1 72 8 de ad be ef 00 00 00 01
1 69 8 ca fe ba be 00 00 00 02
2 200 4 10 00 00 01
2 256 4 10 00 00 02
2 130 4 10 00 00 03
2 251 4 10 00 00 04
2 98 4 10 00 00 05

// ==== sources.f ====
rtl/eth_pkg.sv
rtl/crc32_eth_x32.sv
rtl/tx_word_pacer.sv
rtl/rmii_tx_mac.sv
rtl/rmii_mcu_bridge.sv
tests/tb_rmii_mcu_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rmii_mcu_bridge \
	-f sources.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// ==== tests/tb_rmii_mcu_bridge.sv ====
`timescale 1ns/1ps

module tb_rmii_mcu_bridge;
	import eth_pkg::*;

	// Cycle limits for the wait loops
	localparam int WRITE_LIMIT = 4000;
	localparam int DRAIN_LIMIT = 20000;

	logic       clk_50mhz;
	logic       reset;
	host_word_t host_word;
	logic       host_write;
	logic       host_ready;
	logic       rmii_rx_en;
	logic [1:0] rmii_rxd;

	// Fixed seed for write gaps and filler bytes
	int seed = 92596;

	int check_count = 0;
	int error_count = 0;
	int stall_count = 0;
	int frames_tx = 0;
	int frames_rx = 0;

	// Payload of the frame being written
	logic [7:0] payload [$];

	// Wire bytes still to come and the wire length of each frame
	logic [7:0] exp_bytes [$];
	int         exp_len [$];

	// Receive side assembly
	logic [7:0] rx_bytes [$];
	logic [7:0] cur_byte = '0;
	int         pair_idx = 0;
	logic       in_frame = 1'b0;

	rmii_mcu_bridge rmii_mcu_bridge_inst (
		.clk_50mhz  (clk_50mhz),
		.reset      (reset),
		.host_word  (host_word),
		.host_write (host_write),
		.host_ready (host_ready),
		.rmii_rx_en (rmii_rx_en),
		.rmii_rxd   (rmii_rxd)
	);

	// 50 MHz clock
	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	////////////////////////////////////////////////////////////
	// Checks and reference model

	task automatic compare_value(input string name, input int got, input int expected);
		check_count++;
		assert (got == expected) else begin
			$display("FAILED at %0t ns: %s got %0d expected %0d",
				$time, name, got, expected);
			error_count++;
		end
	endtask

	// Reflected CRC-32 step over one byte taken low bit first
	// Polynomial 0xEDB88320 in reflected form
	function automatic logic [31:0] crc_next_byte(logic [31:0] crc_in, logic [7:0] value);
		logic [31:0] c;
		int          k;
		c = crc_in ^ {24'h0, value};
		for (k = 0; k < 8; k++) begin
			c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
		end
		return c;
	endfunction

	// Closing line and verdict
	task automatic finish_run();
		$display("Checks: %0d  Errors: %0d  Frames sent: %0d  Frames received: %0d",
			check_count, error_count, frames_tx, frames_rx);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Host side

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk_50mhz);
			#2;
		end
	endtask

	// Write one word once the buffer has room
	task automatic write_word(input host_word_t w);
		int waited;
		waited = 0;
		while (!host_ready && waited < WRITE_LIMIT) begin
			stall_count++;
			idle_cycles(1);
			waited++;
		end
		check_count++;
		assert (host_ready) else begin
			$display("Timeout: host_ready stayed low for %0d cycles", WRITE_LIMIT);
			error_count++;
			finish_run();
		end
		host_word  = w;
		host_write = 1'b1;
		idle_cycles(1);
		host_write = 1'b0;
	endtask

	// Queue the expected wire bytes before writing the frame word by word
	task automatic send_frame(input int mode);
		host_word_t  w;
		logic [31:0] crc_ref;
		int          len;
		int          nwords;
		int          k;
		int          j;
		len    = payload.size();
		nwords = (len + 3) / 4;
		// All-ones seed and final inversion
		crc_ref = 32'hFFFFFFFF;
		for (k = 0; k < len; k++) begin
			crc_ref = crc_next_byte(crc_ref, payload[k]);
		end
		crc_ref = ~crc_ref;
		// Preamble and SFD followed by payload and FCS low byte first
		for (k = 0; k < 7; k++) begin
			exp_bytes.push_back(8'h55);
		end
		exp_bytes.push_back(8'hD5);
		for (k = 0; k < len; k++) begin
			exp_bytes.push_back(payload[k]);
		end
		for (k = 0; k < 4; k++) begin
			exp_bytes.push_back(crc_ref[8 * k +: 8]);
		end
		exp_len.push_back(len + 12);
		frames_tx++;
		// First byte of each word in the top lane
		for (k = 0; k < nwords; k++) begin
			w = '0;
			for (j = 0; j < 4 && 4 * k + j < len; j++) begin
				w.data[31 - 8 * j -: 8] = payload[4 * k + j];
			end
			w.bytes_valid = (len - 4 * k >= 4) ? 3'd4 : 3'(len - 4 * k);
			w.last        = (k == nwords - 1);
			write_word(w);
			// Burst frames get random gaps of 0 to 3 cycles
			if (mode == 2)
				idle_cycles($unsigned($random(seed)) % 4);
		end
	endtask

	task automatic wait_until_drained();
		int waited;
		waited = 0;
		while ((exp_len.size() != 0 || rmii_rx_en) && waited < DRAIN_LIMIT) begin
			idle_cycles(1);
			waited++;
		end
		check_count++;
		assert (exp_len.size() == 0 && !rmii_rx_en) else begin
			$display("Timeout: %0d frames never came out on RMII", exp_len.size());
			error_count++;
			finish_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// RMII capture sampled mid-cycle

	task automatic check_frame();
		logic [7:0] e;
		int         exp_n;
		int         i;
		frames_rx++;
		check_count++;
		assert (exp_len.size() != 0) else begin
			$display("Unexpected frame of %0d bytes on RMII", rx_bytes.size());
			error_count++;
			return;
		end
		exp_n = exp_len.pop_front();
		compare_value("rmii byte count", rx_bytes.size(), exp_n);
		compare_value("rmii pairs left over", pair_idx, 0);
		for (i = 0; i < exp_n; i++) begin
			e = exp_bytes.pop_front();
			if (i < rx_bytes.size()) begin
				check_count++;
				assert (rx_bytes[i] == e) else begin
					$display("FAILED at %0t ns: rmii_rxd frame %0d byte %0d got %h expected %h",
						$time, frames_rx, i, rx_bytes[i], e);
					error_count++;
				end
			end
		end
	endtask

	// Pairs fill each byte from bit 0 upward
	always @(negedge clk_50mhz) begin
		if (rmii_rx_en) begin
			in_frame = 1'b1;
			cur_byte[2 * pair_idx +: 2] = rmii_rxd;
			if (pair_idx == 3) begin
				rx_bytes.push_back(cur_byte);
				pair_idx = 0;
			end else begin
				pair_idx++;
			end
		end else if (in_frame) begin
			check_frame();
			in_frame = 1'b0;
			pair_idx = 0;
			rx_bytes.delete();
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		string      line;
		logic [7:0] b;
		int         fd;
		int         code;
		int         mode;
		int         len;
		int         nlisted;
		int         i;
		reset      = 1'b1;
		host_write = 1'b0;
		host_word  = '0;
		repeat (2) @(posedge clk_50mhz);
		#2;
		reset = 1'b0;
		compare_value("rmii_rx_en", rmii_rx_en, 0);
		compare_value("host_ready", host_ready, 1);

		fd = $fopen("tests/frames_input.txt", "r");
		check_count++;
		assert (fd != 0) else begin
			$display("Could not open tests/frames_input.txt");
			error_count++;
			finish_run();
		end
		// Two comment lines at the top
		repeat (2) code = $fgets(line, fd);

		while ($fscanf(fd, "%d %d %d", mode, len, nlisted) == 3) begin
			check_count++;
			assert (len >= 64 && len <= 4 * BUF_WORDS && nlisted <= len) else begin
				$display("Frame %0d in the data file has a bad length", frames_tx);
				error_count++;
				finish_run();
			end
			payload.delete();
			for (i = 0; i < nlisted; i++) begin
				code = $fscanf(fd, "%h", b);
				compare_value("data file byte read", code, 1);
				payload.push_back(b);
			end
			// Unlisted bytes are filler
			for (i = nlisted; i < len; i++) begin
				payload.push_back(8'($random(seed)));
			end
			send_frame(mode);
			if (mode == 0)
				wait_until_drained();
		end
		$fclose(fd);

		wait_until_drained();
		compare_value("received frame count", frames_rx, frames_tx);
		check_count++;
		assert (stall_count > 0) else begin
			$display("host_ready never went low, the buffer was never full");
			error_count++;
		end
		finish_run();
	end

endmodule

// ==== rtl/rmii_mcu_bridge.sv ====
`timescale 1ns/1ps

module rmii_mcu_bridge (
	input  logic                clk_50mhz,
	input  logic                reset,
	input  eth_pkg::host_word_t host_word,
	input  logic                host_write,
	output logic                host_ready,
	output logic                rmii_rx_en,
	output logic [1:0]          rmii_rxd
);
	import eth_pkg::*;

	// Gated word stream, shared by CRC and transmitter
	eth_tx_bus_t tx_bus;

	// Transmitter free for a new frame
	logic        mac_ready;

	// Finished FCS, ready for MSB-first sending
	eth_word_t   fcs;

	////////////////////////////////////////////////////////////
	// Store-and-forward buffer and word gate

	tx_word_pacer pacer_inst (
		.clk_50mhz  (clk_50mhz),
		.reset      (reset),
		.host_word  (host_word),
		.host_write (host_write),
		.host_ready (host_ready),
		.mac_ready  (mac_ready),
		.tx_bus     (tx_bus)
	);

	////////////////////////////////////////////////////////////
	// FCS over the gated stream

	crc32_eth_x32 crc_inst (
		.clk_50mhz (clk_50mhz),
		.reset     (reset),
		.tx_bus    (tx_bus),
		.fcs       (fcs)
	);

	////////////////////////////////////////////////////////////
	// RMII serializer toward the MCU

	rmii_tx_mac mac_inst (
		.clk_50mhz  (clk_50mhz),
		.reset      (reset),
		.tx_bus     (tx_bus),
		.fcs        (fcs),
		.mac_ready  (mac_ready),
		.rmii_rx_en (rmii_rx_en),
		.rmii_rxd   (rmii_rxd)
	);

endmodule

// ==== rtl/rmii_tx_mac.sv ====
`timescale 1ns/1ps

module rmii_tx_mac (
	input  logic                 clk_50mhz,
	input  logic                 reset,
	input  eth_pkg::eth_tx_bus_t tx_bus,
	input  eth_pkg::eth_word_t   fcs,
	output logic                 mac_ready,
	output logic                 rmii_rx_en,
	output logic [1:0]           rmii_rxd
);
	import eth_pkg::*;

	// One delay stage, a word and its byte count
	typedef struct packed {
		eth_word_t   data;
		byte_count_t bytes_valid;
	} stage_t;

	tx_state_t   state;

	// Bit pair index within the current word
	logic [3:0]  pair_count;

	// Stage 2 is the word on the pins
	stage_t      dly [3];

	logic        word_end;
	logic        drain_1;
	logic        drain_2;
	logic        last_byte;

	// Pick a bit pair
	// Bytes go high to low, pairs within a byte low to high
	function automatic logic [1:0] pair_sel(eth_word_t word, logic [3:0] idx);
		logic [4:0] lsb;
		lsb = {~idx[3:2], idx[1:0], 1'b0};
		return word[lsb +: 2];
	endfunction

	assign word_end  = (pair_count == 4'd15);

	// No new word at a slot boundary means the frame has ended
	assign drain_1   = (state == data) && word_end && !tx_bus.data_valid;
	assign drain_2   = (state == data_last1) && word_end;

	// Final pair of the last valid byte in a partial word
	assign last_byte = (pair_count[1:0] == 2'b11) &&
		(({1'b0, pair_count[3:2]} + 3'd1) == dly[2].bytes_valid);

	////////////////////////////////////////////////////////////
	// Word delay line

	// Shifted by the gate while words arrive
	// Then stepped by hand to drain the last two words
	always_ff @(posedge clk_50mhz) begin
		if (tx_bus.data_valid) begin
			dly[0] <= '{data: tx_bus.data, bytes_valid: tx_bus.bytes_valid};
			dly[1] <= dly[0];
			dly[2] <= dly[1];
		end else if (drain_1) begin
			dly[1] <= dly[0];
			dly[2] <= dly[1];
		end else if (drain_2) begin
			dly[2] <= dly[1];
		end
	end

	////////////////////////////////////////////////////////////
	// Transmit FSM

	always_ff @(posedge clk_50mhz) begin
		if (reset) begin
			state      <= idle;
			pair_count <= '0;
			mac_ready  <= 1'b1;
			rmii_rx_en <= 1'b0;
			rmii_rxd   <= 2'b00;
		end else begin
			case (state)
				idle: begin
					// End of a frame, drop the pins and free up
					if (rmii_rx_en) begin
						rmii_rx_en <= 1'b0;
						rmii_rxd   <= 2'b00;
						mac_ready  <= 1'b1;
					end
					if (tx_bus.start) begin
						mac_ready <= 1'b0;
					end
					// First word in, begin the preamble
					if (tx_bus.data_valid) begin
						pair_count <= '0;
						state      <= preamble_1;
					end
				end

				// Four bytes of 0x55
				preamble_1: begin
					rmii_rx_en <= 1'b1;
					rmii_rxd   <= 2'b01;
					pair_count <= pair_count + 1'b1;
					if (word_end) begin
						state <= preamble_2;
					end
				end

				// Three more 0x55, then 0xD5
				// Only the final pair of 0xD5 differs
				preamble_2: begin
					rmii_rx_en <= 1'b1;
					rmii_rxd   <= word_end ? 2'b11 : 2'b01;
					pair_count <= pair_count + 1'b1;
					if (word_end) begin
						state <= data;
					end
				end

				// Full payload words
				data: begin
					rmii_rx_en <= 1'b1;
					rmii_rxd   <= pair_sel(dly[2].data, pair_count);
					pair_count <= pair_count + 1'b1;
					if (drain_1) begin
						state <= data_last1;
					end
				end

				// Next to last word, always full
				data_last1: begin
					rmii_rx_en <= 1'b1;
					rmii_rxd   <= pair_sel(dly[2].data, pair_count);
					pair_count <= pair_count + 1'b1;
					if (word_end) begin
						state <= data_last2;
					end
				end

				// Last word, cut short after its valid bytes
				data_last2: begin
					rmii_rx_en <= 1'b1;
					rmii_rxd   <= pair_sel(dly[2].data, pair_count);
					pair_count <= pair_count + 1'b1;
					if (last_byte || word_end) begin
						pair_count <= '0;
						state      <= eth_pkg::fcs;
					end
				end

				// Sixteen pairs of FCS
				eth_pkg::fcs: begin
					rmii_rx_en <= 1'b1;
					rmii_rxd   <= pair_sel(fcs, pair_count);
					pair_count <= pair_count + 1'b1;
					if (word_end) begin
						state <= idle;
					end
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

// ==== rtl/tx_word_pacer.sv ====
`timescale 1ns/1ps

module tx_word_pacer (
	input  logic                 clk_50mhz,
	input  logic                 reset,
	input  eth_pkg::host_word_t  host_word,
	input  logic                 host_write,
	output logic                 host_ready,
	input  logic                 mac_ready,
	output eth_pkg::eth_tx_bus_t tx_bus
);
	import eth_pkg::*;

	////////////////////////////////////////////////////////////
	// Frame buffer

	host_word_t buf_mem [BUF_WORDS];

	logic [BUF_ADDR_W-1:0] wr_ptr;
	logic [BUF_ADDR_W-1:0] rd_ptr;

	// Words held, one bit wider to tell full from empty
	logic [BUF_ADDR_W:0]   word_count;

	// Complete frames held, including the one in flight
	logic [BUF_ADDR_W:0]   frame_count;

	// Position within the 16-clock word slot
	logic [3:0]            phase;

	// High from start until the last word is read
	logic                  active;

	logic                  wr_accept;
	logic                  rd_take;
	logic                  frame_in;
	logic                  frame_out;

	// Full buffer holds off the host
	assign host_ready = (word_count != (BUF_ADDR_W + 1)'(BUF_WORDS));
	assign wr_accept  = host_write && host_ready;

	// One read per slot while a frame is going out
	assign rd_take    = active && (phase == 4'(WORD_PERIOD - 1));

	assign frame_in   = wr_accept && host_word.last;
	assign frame_out  = rd_take && buf_mem[rd_ptr].last;

	// Buffer storage
	always_ff @(posedge clk_50mhz) begin
		if (wr_accept) begin
			buf_mem[wr_ptr] <= host_word;
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers, counts and the word gate

	always_ff @(posedge clk_50mhz) begin
		if (reset) begin
			wr_ptr             <= '0;
			rd_ptr             <= '0;
			word_count         <= '0;
			frame_count        <= '0;
			phase              <= '0;
			active             <= 1'b0;
			tx_bus.start       <= 1'b0;
			tx_bus.data_valid  <= 1'b0;
			tx_bus.bytes_valid <= '0;
		end else begin
			// Strobes default low
			tx_bus.start       <= 1'b0;
			tx_bus.data_valid  <= 1'b0;
			tx_bus.bytes_valid <= '0;

			if (wr_accept) begin
				wr_ptr <= wr_ptr + 1'b1;
			end

			case ({wr_accept, rd_take})
				2'b10:   word_count <= word_count + 1'b1;
				2'b01:   word_count <= word_count - 1'b1;
				default: word_count <= word_count;
			endcase

			case ({frame_in, frame_out})
				2'b10:   frame_count <= frame_count + 1'b1;
				2'b01:   frame_count <= frame_count - 1'b1;
				default: frame_count <= frame_count;
			endcase

			if (!active) begin
				// Whole frame stored and transmitter free
				if ((frame_count != '0) && mac_ready) begin
					active       <= 1'b1;
					phase        <= '0;
					tx_bus.start <= 1'b1;
				end
			end else begin
				phase <= phase + 1'b1;
				if (rd_take) begin
					tx_bus.data_valid  <= 1'b1;
					tx_bus.bytes_valid <= buf_mem[rd_ptr].bytes_valid;
					tx_bus.data        <= buf_mem[rd_ptr].data;
					rd_ptr             <= rd_ptr + 1'b1;
					// Frame done after the marked word
					if (buf_mem[rd_ptr].last) begin
						active <= 1'b0;
					end
				end
			end
		end
	end

endmodule

// ==== rtl/crc32_eth_x32.sv ====
`timescale 1ns/1ps

module crc32_eth_x32 (
	input  logic                 clk_50mhz,
	input  logic                 reset,
	input  eth_pkg::eth_tx_bus_t tx_bus,
	output eth_pkg::eth_word_t   fcs
);
	import eth_pkg::*;

	// Running remainder, reflected form
	eth_word_t crc_reg;

	// Inverted remainder, still in wire bit order
	eth_word_t crc_final;

	// Fold up to four bytes into the remainder
	// Bytes are taken from the top of the word down
	// Bits within a byte go in low bit first
	function automatic eth_word_t crc_fold(eth_word_t crc_in, eth_word_t word,
		byte_count_t count);
		eth_word_t   c;
		logic [7:0]  b;
		c = crc_in;
		for (int i = 0; i < 4; i++) begin
			if (i < int'(count)) begin
				b = word[(3 - i) * 8 +: 8];
				c = c ^ {24'h0, b};
				for (int k = 0; k < 8; k++) begin
					if (c[0])
						c = (c >> 1) ^ CRC_POLY;
					else
						c = c >> 1;
				end
			end
		end
		return c;
	endfunction

	// Seed on start, fold on each gated word
	always_ff @(posedge clk_50mhz) begin
		if (reset || tx_bus.start) begin
			crc_reg <= CRC_SEED;
		end else if (tx_bus.data_valid) begin
			crc_reg <= crc_fold(crc_reg, tx_bus.data, tx_bus.bytes_valid);
		end
	end

	assign crc_final = ~crc_reg;

	// Byte swap so that MSB-first sending puts the low byte on the wire first
	always_ff @(posedge clk_50mhz) begin
		fcs <= {crc_final[7:0], crc_final[15:8], crc_final[23:16], crc_final[31:24]};
	end

endmodule

// ==== rtl/eth_pkg.sv ====
package eth_pkg;

	////////////////////////////////////////////////////////////
	// Widths and word types

	// One bus word, most significant byte goes out first
	typedef logic [31:0] eth_word_t;

	// Valid bytes in a word, 0 to 4
	typedef logic [2:0] byte_count_t;

	////////////////////////////////////////////////////////////
	// Sizes and constants

	// Clocks per gated word, 32 bits over a 2-bit pin
	localparam int WORD_PERIOD = 16;

	// Store-and-forward buffer depth in words
	localparam int BUF_WORDS = 64;
	localparam int BUF_ADDR_W = 6;

	// Reflected Ethernet polynomial and seed
	localparam eth_word_t CRC_POLY = 32'hEDB88320;
	localparam eth_word_t CRC_SEED = 32'hFFFFFFFF;

	////////////////////////////////////////////////////////////
	// Bundles

	// Gated word stream from the pacer
	// bytes_valid stays zero whenever data_valid is low
	typedef struct packed {
		logic        start;
		logic        data_valid;
		byte_count_t bytes_valid;
		eth_word_t   data;
	} eth_tx_bus_t;

	// One host write, last marks the end of a frame
	typedef struct packed {
		eth_word_t   data;
		byte_count_t bytes_valid;
		logic        last;
	} host_word_t;

	// Transmitter states
	typedef enum logic [2:0] {
		idle,
		preamble_1,
		preamble_2,
		data,
		data_last1,
		data_last2,
		fcs
	} tx_state_t;

endpackage
